// File: project.f
src/mem_map_pkg.sv
src/bus_pkg.sv
src/master_port.sv
src/slave_port_arbiter.sv
src/memory_router.sv
bench/memory_router_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the router testbench with verilator
# a $fatal in the testbench gives a non-zero exit status
set -e

cd "$(dirname "$0")"

verilator --binary \
   -f project.f \
   --top-module memory_router_tb \
   -o memory_router_tb

./obj_dir/memory_router_tb

// File: bench/router_golden.txt
# request tokens are addr(4) wdata(2) strobes(1), strobes = {we_l, re_l}: 3 idle, 1 write, 2 read
# cpu ppu rdma wdma slave_rdata{ioreg,cart,lcdram,wram} | cpu_rd ppu_rd rdma_rd ioreg cart lcdram wram
0000003 0000003 0000003 0000003 11223344 00 00 00 0000003 0000003 0000003 0000003
# cpu writes, one per region
1234A51 0000003 0000003 0000003 11223344 00 00 00 0000003 1234A51 0000003 0000003
B0105C1 0000003 0000003 0000003 11223344 00 00 00 0000003 B0105C1 0000003 0000003
81233C1 0000003 0000003 0000003 11223344 00 00 00 0000003 0000003 81233C1 0000003
C456771 0000003 0000003 0000003 11223344 00 00 00 0000003 0000003 0000003 C456771
FF10801 0000003 0000003 0000003 11223344 00 00 00 FF10801 0000003 0000003 0000003
7FFF011 0000003 0000003 0000003 11223344 00 00 00 0000003 7FFF011 0000003 0000003
9FFF021 0000003 0000003 0000003 11223344 00 00 00 0000003 0000003 9FFF021 0000003
DFFF031 0000003 0000003 0000003 11223344 00 00 00 0000003 0000003 0000003 DFFF031
FFFF041 0000003 0000003 0000003 11223344 00 00 00 FFFF041 0000003 0000003 0000003
# oam and lcd registers, dma and hram on io, holes
FE00101 0000003 0000003 0000003 11223344 00 00 00 0000003 0000003 FE00101 0000003
FE9F111 0000003 0000003 0000003 11223344 00 00 00 0000003 0000003 FE9F111 0000003
FF40121 0000003 0000003 0000003 11223344 00 00 00 0000003 0000003 FF40121 0000003
FF4F131 0000003 0000003 0000003 11223344 00 00 00 0000003 0000003 FF4F131 0000003
FF6B141 0000003 0000003 0000003 11223344 00 00 00 0000003 0000003 FF6B141 0000003
FF46151 0000003 0000003 0000003 11223344 00 00 00 FF46151 0000003 0000003 0000003
FF80161 0000003 0000003 0000003 11223344 00 00 00 FF80161 0000003 0000003 0000003
E000002 0000003 0000003 0000003 11223344 00 00 00 0000003 0000003 0000003 0000003
FEA0002 0000003 0000003 0000003 11223344 00 00 00 0000003 0000003 0000003 0000003
FF44002 0000003 0000003 0000003 11223344 33 00 00 0000003 0000003 FF44002 0000003
FF6C171 0000003 0000003 0000003 11223344 00 00 00 FF6C171 0000003 0000003 0000003
# parallel reads, each master gets its own slave byte
C000002 8000002 0100002 0000003 A1B2C3D4 D4 C3 B2 0000003 0100002 8000002 C000002
FF00002 9000551 A800002 0000003 5A6B7C8D 5A 00 6B FF00002 A800002 9000551 0000003
0000003 FE10002 FF47002 0000003 01020304 00 03 03 0000003 0000003 FE10002 0000003
# priority
C100111 C200002 0000003 C300331 11223344 00 44 00 0000003 0000003 0000003 C100111
0000003 C200002 0000003 C300331 11223344 00 44 00 0000003 0000003 0000003 C200002
0000003 0000003 0000003 C300331 11223344 00 00 00 0000003 0000003 0000003 C300331
0000003 0000003 FF05002 FF06991 11223344 00 00 11 FF05002 0000003 0000003 0000003
0000003 0000003 0000003 FF06991 11223344 00 00 00 FF06991 0000003 0000003 0000003
0000003 0000003 4000002 8800421 11223344 00 00 22 0000003 4000002 8800421 0000003
2000002 3000002 0000003 0000003 11223344 22 22 00 0000003 2000002 0000003 0000003
# idle, strobes high
0000003 0000003 0000003 0000003 FFFFFFFF 00 00 00 0000003 0000003 0000003 0000003
C0001F3 8000203 0100003 FF40553 FFFFFFFF 00 00 00 0000003 0000003 0000003 0000003

// File: bench/memory_router_tb.sv
`timescale 1ns/1ns

module memory_router_tb;
   import mem_map_pkg::*;
   import bus_pkg::*;

   localparam int CLK_PERIOD    = 40;
   localparam int RESET_CYCLES  = 5;
   localparam int TIMEOUT_SLACK = 20;
   localparam int REQ_PAD       = 32 - SLAVE_REQ_W;   // widen a slave request to 32 bits

   logic clk;
   logic rst_n;

   master_req_t  cpu_req;
   master_req_t  ppu_req;
   addr_t        rdma_addr;
   logic         rdma_re_l;
   addr_t        wdma_addr;
   data_t        wdma_wdata;
   logic         wdma_we_l;
   slave_rdata_t slave_rdata;
   data_t        cpu_rdata;
   data_t        ppu_rdata;
   data_t        rdma_rdata;
   slave_req_t   ioreg_req;
   slave_req_t   cart_req;
   slave_req_t   lcdram_req;
   slave_req_t   wram_req;

   // tokens are {addr, wdata, 2'b00, we_l, re_l}
   logic [27:0] cpu_tok[$];
   logic [27:0] ppu_tok[$];
   logic [27:0] rdma_tok[$];
   logic [27:0] wdma_tok[$];
   logic [SLAVE_RDATA_W-1:0] rdata_tok[$];
   logic [7:0]  exp_cpu_rdata[$];
   logic [7:0]  exp_ppu_rdata[$];
   logic [7:0]  exp_rdma_rdata[$];
   logic [27:0] exp_ioreg[$];
   logic [27:0] exp_cart[$];
   logic [27:0] exp_lcdram[$];
   logic [27:0] exp_wram[$];

   int cycle_count = 0;
   int cycle_limit = 0;

   memory_router u_dut (
      .cpu_req     (cpu_req),
      .ppu_req     (ppu_req),
      .rdma_addr   (rdma_addr),
      .rdma_re_l   (rdma_re_l),
      .wdma_addr   (wdma_addr),
      .wdma_wdata  (wdma_wdata),
      .wdma_we_l   (wdma_we_l),
      .slave_rdata (slave_rdata),
      .cpu_rdata   (cpu_rdata),
      .ppu_rdata   (ppu_rdata),
      .rdma_rdata  (rdma_rdata),
      .ioreg_req   (ioreg_req),
      .cart_req    (cart_req),
      .lcdram_req  (lcdram_req),
      .wram_req    (wram_req)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // counts vector cycles once reset is released
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cycle_count <= 0;
      end else begin
         cycle_count <= cycle_count + 1;
         if (cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d clock cycles", cycle_limit);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
         end
      end
   end

   function automatic master_req_t req_from_token(input logic [27:0] tok);
      master_req_t r;
      r.addr  = tok[27:12];
      r.wdata = tok[11:4];
      r.we_l  = tok[1];
      r.re_l  = tok[0];
      return r;
   endfunction

   function automatic slave_req_t slave_req_from_token(input logic [27:0] tok);
      slave_req_t s;
      s.addr  = tok[27:12];
      s.wdata = tok[11:4];
      s.we_l  = tok[1];
      s.re_l  = tok[0];
      return s;
   endfunction

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         $display("TESTS FAILED");
         $fatal(1, "output compare failed");
      end
   endtask

   task automatic load_vectors();
      int          fd;
      int          got;
      string       line;
      logic [27:0] t_cpu;
      logic [27:0] t_ppu;
      logic [27:0] t_rdma;
      logic [27:0] t_wdma;
      logic [SLAVE_RDATA_W-1:0] t_rdata;
      logic [7:0]  e_cpu;
      logic [7:0]  e_ppu;
      logic [7:0]  e_rdma;
      logic [27:0] e_io;
      logic [27:0] e_cart;
      logic [27:0] e_lcd;
      logic [27:0] e_wram;
      fd = $fopen("bench/router_golden.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file bench/router_golden.txt");
         $display("TESTS FAILED");
         $fatal(1, "no vector file");
      end
      while (!$feof(fd)) begin
         line = "";
         got = $fgets(line, fd);
         if (got == 0 || line.len() < 2 || line[0] == "#") begin
            continue;   // comments and blank lines
         end
         got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                       t_cpu, t_ppu, t_rdma, t_wdma, t_rdata, e_cpu, e_ppu, e_rdma,
                       e_io, e_cart, e_lcd, e_wram);
         if (got != 12) begin
            $display("badly formed line in the vector file: %s", line);
            $display("TESTS FAILED");
            $fatal(1, "bad vector line");
         end
         cpu_tok.push_back(t_cpu);
         ppu_tok.push_back(t_ppu);
         rdma_tok.push_back(t_rdma);
         wdma_tok.push_back(t_wdma);
         rdata_tok.push_back(t_rdata);
         exp_cpu_rdata.push_back(e_cpu);
         exp_ppu_rdata.push_back(e_ppu);
         exp_rdma_rdata.push_back(e_rdma);
         exp_ioreg.push_back(e_io);
         exp_cart.push_back(e_cart);
         exp_lcdram.push_back(e_lcd);
         exp_wram.push_back(e_wram);
      end
      $fclose(fd);
   endtask

   // rdma only uses addr and re_l, wdma only addr, wdata and we_l
   task automatic drive_vector(input int i);
      cpu_req     <= req_from_token(cpu_tok[i]);
      ppu_req     <= req_from_token(ppu_tok[i]);
      rdma_addr   <= rdma_tok[i][27:12];
      rdma_re_l   <= rdma_tok[i][0];
      wdma_addr   <= wdma_tok[i][27:12];
      wdma_wdata  <= wdma_tok[i][11:4];
      wdma_we_l   <= wdma_tok[i][1];
      slave_rdata <= rdata_tok[i];
   endtask

   task automatic compare_outputs(input int i);
      check($sformatf("vector %0d cpu_rdata", i), {24'b0, cpu_rdata}, {24'b0, exp_cpu_rdata[i]});
      check($sformatf("vector %0d ppu_rdata", i), {24'b0, ppu_rdata}, {24'b0, exp_ppu_rdata[i]});
      check($sformatf("vector %0d rdma_rdata", i), {24'b0, rdma_rdata},
            {24'b0, exp_rdma_rdata[i]});
      check($sformatf("vector %0d ioreg_req", i), {{REQ_PAD{1'b0}}, ioreg_req},
            {{REQ_PAD{1'b0}}, slave_req_from_token(exp_ioreg[i])});
      check($sformatf("vector %0d cart_req", i), {{REQ_PAD{1'b0}}, cart_req},
            {{REQ_PAD{1'b0}}, slave_req_from_token(exp_cart[i])});
      check($sformatf("vector %0d lcdram_req", i), {{REQ_PAD{1'b0}}, lcdram_req},
            {{REQ_PAD{1'b0}}, slave_req_from_token(exp_lcdram[i])});
      check($sformatf("vector %0d wram_req", i), {{REQ_PAD{1'b0}}, wram_req},
            {{REQ_PAD{1'b0}}, slave_req_from_token(exp_wram[i])});
   endtask

   initial begin
      cpu_req     = '{addr: 16'h0000, wdata: 8'h00, we_l: 1'b1, re_l: 1'b1};
      ppu_req     = '{addr: 16'h0000, wdata: 8'h00, we_l: 1'b1, re_l: 1'b1};
      rdma_addr   = 16'h0000;
      rdma_re_l   = 1'b1;
      wdma_addr   = 16'h0000;
      wdma_wdata  = 8'h00;
      wdma_we_l   = 1'b1;
      slave_rdata = 32'h0000_0000;
      rst_n       = 1'b0;

      load_vectors();
      if (cpu_tok.size() == 0) begin
         $display("the vector file holds no vectors");
         $display("TESTS FAILED");
         $fatal(1, "empty vector file");
      end
      cycle_limit = cpu_tok.size() + TIMEOUT_SLACK;

      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      // apply on rise, sample on fall
      for (int i = 0; i < cpu_tok.size(); i++) begin
         @(posedge clk);
         drive_vector(i);
         @(negedge clk);
         compare_outputs(i);
      end

      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: src/memory_router.sv
`timescale 1ns/1ns

module memory_router (
   input  bus_pkg::master_req_t  cpu_req,
   input  bus_pkg::master_req_t  ppu_req,
   input  mem_map_pkg::addr_t    rdma_addr,
   input  logic                  rdma_re_l,
   input  mem_map_pkg::addr_t    wdma_addr,
   input  mem_map_pkg::data_t    wdma_wdata,
   input  logic                  wdma_we_l,
   input  bus_pkg::slave_rdata_t slave_rdata,
   output mem_map_pkg::data_t    cpu_rdata,
   output mem_map_pkg::data_t    ppu_rdata,
   output mem_map_pkg::data_t    rdma_rdata,
   output bus_pkg::slave_req_t   ioreg_req,
   output bus_pkg::slave_req_t   cart_req,
   output bus_pkg::slave_req_t   lcdram_req,
   output bus_pkg::slave_req_t   wram_req
);
   import mem_map_pkg::*;
   import bus_pkg::*;

   master_req_t rdma_req;
   master_req_t wdma_req;
   region_e     cpu_region;
   region_e     ppu_region;
   region_e     rdma_region;
   region_e     wdma_region;

   // dma ports are one-directional
   assign rdma_req = '{addr: rdma_addr, wdata: data_t'(0), we_l: 1'b1, re_l: rdma_re_l};
   assign wdma_req = '{addr: wdma_addr, wdata: wdma_wdata, we_l: wdma_we_l, re_l: 1'b1};

   master_port u_cpu_port (
      .req         (cpu_req),
      .slave_rdata (slave_rdata),
      .region      (cpu_region),
      .rdata       (cpu_rdata)
   );

   master_port u_ppu_port (
      .req         (ppu_req),
      .slave_rdata (slave_rdata),
      .region      (ppu_region),
      .rdata       (ppu_rdata)
   );

   master_port u_rdma_port (
      .req         (rdma_req),
      .slave_rdata (slave_rdata),
      .region      (rdma_region),
      .rdata       (rdma_rdata)
   );

   master_port u_wdma_port (
      .req         (wdma_req),
      .slave_rdata (slave_rdata),
      .region      (wdma_region),
      .rdata       ()             // write only
   );

   slave_port_arbiter #(.SLAVE(REGION_IOREG)) u_ioreg_arb (
      .cpu_req (cpu_req),  .ppu_req (ppu_req),  .rdma_req (rdma_req),  .wdma_req (wdma_req),
      .cpu_region  (cpu_region),
      .ppu_region  (ppu_region),
      .rdma_region (rdma_region),
      .wdma_region (wdma_region),
      .slave_req   (ioreg_req)
   );

   slave_port_arbiter #(.SLAVE(REGION_CART)) u_cart_arb (
      .cpu_req (cpu_req),  .ppu_req (ppu_req),  .rdma_req (rdma_req),  .wdma_req (wdma_req),
      .cpu_region  (cpu_region),
      .ppu_region  (ppu_region),
      .rdma_region (rdma_region),
      .wdma_region (wdma_region),
      .slave_req   (cart_req)
   );

   slave_port_arbiter #(.SLAVE(REGION_LCDRAM)) u_lcdram_arb (
      .cpu_req (cpu_req),  .ppu_req (ppu_req),  .rdma_req (rdma_req),  .wdma_req (wdma_req),
      .cpu_region  (cpu_region),
      .ppu_region  (ppu_region),
      .rdma_region (rdma_region),
      .wdma_region (wdma_region),
      .slave_req   (lcdram_req)
   );

   slave_port_arbiter #(.SLAVE(REGION_WRAM)) u_wram_arb (
      .cpu_req (cpu_req),  .ppu_req (ppu_req),  .rdma_req (rdma_req),  .wdma_req (wdma_req),
      .cpu_region  (cpu_region),
      .ppu_region  (ppu_region),
      .rdma_region (rdma_region),
      .wdma_region (wdma_region),
      .slave_req   (wram_req)
   );

endmodule

// File: src/slave_port_arbiter.sv
`timescale 1ns/1ns

module slave_port_arbiter #(
   parameter mem_map_pkg::region_e SLAVE = mem_map_pkg::REGION_WRAM
) (
   input  bus_pkg::master_req_t cpu_req,
   input  bus_pkg::master_req_t ppu_req,
   input  bus_pkg::master_req_t rdma_req,
   input  bus_pkg::master_req_t wdma_req,
   input  mem_map_pkg::region_e cpu_region,
   input  mem_map_pkg::region_e ppu_region,
   input  mem_map_pkg::region_e rdma_region,
   input  mem_map_pkg::region_e wdma_region,
   output bus_pkg::slave_req_t  slave_req
);
   import bus_pkg::*;

   master_sel_e sel;

   function automatic slave_req_t to_slave(input master_req_t m);
      slave_req_t s;
      s.addr  = m.addr;
      s.wdata = m.wdata;
      s.we_l  = m.we_l;
      s.re_l  = m.re_l;
      return s;
   endfunction

   // fixed priority, cpu first
   always_comb begin
      if (cpu_region == SLAVE) begin
         sel = SEL_CPU;
      end else if (ppu_region == SLAVE) begin
         sel = SEL_PPU;
      end else if (rdma_region == SLAVE) begin
         sel = SEL_RDMA;
      end else if (wdma_region == SLAVE) begin
         sel = SEL_WDMA;
      end else begin
         sel = SEL_NONE;
      end
   end

   // winner takes the whole request
   always_comb begin
      case (sel)
         SEL_CPU:  slave_req = to_slave(cpu_req);
         SEL_PPU:  slave_req = to_slave(ppu_req);
         SEL_RDMA: slave_req = to_slave(rdma_req);
         SEL_WDMA: slave_req = to_slave(wdma_req);
         default:  slave_req = SLAVE_REQ_IDLE;
      endcase
   end

endmodule

// File: src/master_port.sv
`timescale 1ns/1ns

module master_port (
   input  bus_pkg::master_req_t  req,
   input  bus_pkg::slave_rdata_t slave_rdata,
   output mem_map_pkg::region_e  region,
   output mem_map_pkg::data_t    rdata
);
   import mem_map_pkg::*;

   logic    active;
   logic    reading;
   region_e hit;

   function automatic logic is_lcd_reg(input addr_t a);
      case (a)
         LCDC, STAT, SCY, SCX, LY, LYC: return 1'b1;
         BGP, OBP0, OBP1, WY, WX, VBK:  return 1'b1;
         BCPS, BCPD, OCPS, OCPD:        return 1'b1;   // palette regs
         default:                       return 1'b0;
      endcase
   endfunction

   // lcd regs must be checked before the io window
   function automatic region_e decode(input addr_t a);
      if (in_range(a, CART_LO, CART_HI) || in_range(a, EXT_LO, EXT_HI)) begin
         return REGION_CART;
      end
      if (in_range(a, LCDRAM_LO, LCDRAM_HI)) begin
         return REGION_LCDRAM;
      end
      if (in_range(a, WRAM_LO, WRAM_HI)) begin
         return REGION_WRAM;
      end
      if (in_range(a, OAM_LO, OAM_HI) || is_lcd_reg(a)) begin
         return REGION_LCDRAM;
      end
      if (in_span(a, IOREG_LO, IOREG_HI)) begin
         return REGION_IOREG;
      end
      // echo ram and FEA0-FEFF
      return REGION_NONE;
   endfunction

   assign active  = ~req.we_l | ~req.re_l;
   assign reading = ~req.re_l;

   always_comb begin
      hit = decode(req.addr);
   end

   assign region = active ? hit : REGION_NONE;

   // return byte follows the region, won or not
   always_comb begin
      rdata = '0;
      if (reading) begin
         case (region)
            REGION_IOREG:  rdata = slave_rdata.ioreg;
            REGION_CART:   rdata = slave_rdata.cart;
            REGION_LCDRAM: rdata = slave_rdata.lcdram;
            REGION_WRAM:   rdata = slave_rdata.wram;
            default:       rdata = '0;   // unmapped reads as zero
         endcase
      end
   end

endmodule

// File: src/bus_pkg.sv
package bus_pkg;

   // request as a master drives it, strobes active low
   typedef struct packed {
      mem_map_pkg::addr_t addr;
      mem_map_pkg::data_t wdata;
      logic               we_l;
      logic               re_l;
   } master_req_t;

   // request as a slave sees it after arbitration
   typedef struct packed {
      mem_map_pkg::addr_t addr;
      mem_map_pkg::data_t wdata;
      logic               we_l;
      logic               re_l;
   } slave_req_t;

   // read bytes coming back from the slaves
   typedef struct packed {
      mem_map_pkg::data_t ioreg;
      mem_map_pkg::data_t cart;
      mem_map_pkg::data_t lcdram;
      mem_map_pkg::data_t wram;
   } slave_rdata_t;

   // arbiter winner
   typedef enum logic [2:0] {
      SEL_NONE = 3'd0,
      SEL_CPU  = 3'd1,
      SEL_PPU  = 3'd2,
      SEL_RDMA = 3'd3,
      SEL_WDMA = 3'd4
   } master_sel_e;

   localparam int SLAVE_REQ_W   = $bits(slave_req_t);     // 26
   localparam int SLAVE_RDATA_W = $bits(slave_rdata_t);   // 32

   // nothing selected
   localparam slave_req_t SLAVE_REQ_IDLE = '{
      addr:  16'h0000,
      wdata: 8'h00,
      we_l:  1'b1,
      re_l:  1'b1
   };

endpackage

// File: src/mem_map_pkg.sv
package mem_map_pkg;

   typedef logic [15:0] addr_t;   // cpu address space
   typedef logic [7:0]  data_t;

   // where an access lands
   typedef enum logic [2:0] {
      REGION_NONE   = 3'd0,
      REGION_IOREG  = 3'd1,
      REGION_CART   = 3'd2,
      REGION_LCDRAM = 3'd3,
      REGION_WRAM   = 3'd4
   } region_e;

   // lower bound inclusive, upper bound exclusive
   localparam addr_t CART_LO   = 16'h0000;
   localparam addr_t CART_HI   = 16'h8000;
   localparam addr_t LCDRAM_LO = 16'h8000;   // vram
   localparam addr_t LCDRAM_HI = 16'hA000;
   localparam addr_t EXT_LO    = 16'hA000;   // external expansion ram on the cart
   localparam addr_t EXT_HI    = 16'hC000;
   localparam addr_t WRAM_LO   = 16'hC000;
   localparam addr_t WRAM_HI   = 16'hE000;
   localparam addr_t OAM_LO    = 16'hFE00;
   localparam addr_t OAM_HI    = 16'hFEA0;

   // io range runs to the top of the map, so HI is the last address
   localparam addr_t IOREG_LO  = 16'hFF00;
   localparam addr_t IOREG_HI  = 16'hFFFF;

   // lcd control registers, served by lcd ram
   localparam addr_t LCDC = 16'hFF40;
   localparam addr_t STAT = 16'hFF41;
   localparam addr_t SCY  = 16'hFF42;
   localparam addr_t SCX  = 16'hFF43;
   localparam addr_t LY   = 16'hFF44;
   localparam addr_t LYC  = 16'hFF45;
   localparam addr_t BGP  = 16'hFF47;   // FF46 is oam dma, stays on io
   localparam addr_t OBP0 = 16'hFF48;
   localparam addr_t OBP1 = 16'hFF49;
   localparam addr_t WY   = 16'hFF4A;
   localparam addr_t WX   = 16'hFF4B;
   localparam addr_t VBK  = 16'hFF4F;   // vram bank
   localparam addr_t BCPS = 16'hFF68;
   localparam addr_t BCPD = 16'hFF69;
   localparam addr_t OCPS = 16'hFF6A;
   localparam addr_t OCPD = 16'hFF6B;

   // half open window
   function automatic logic in_range(
      input addr_t a,
      input addr_t lo,
      input addr_t hi
   );
      return (a >= lo) && (a < hi);
   endfunction

   // closed window, for ranges that end at FFFF
   function automatic logic in_span(
      input addr_t a,
      input addr_t lo,
      input addr_t last
   );
      return (a >= lo) && (a <= last);
   endfunction

endpackage
